//--- common/rv_pipe_config.svh
`ifndef RV_PIPE_CONFIG_SVH
`define RV_PIPE_CONFIG_SVH

// Datapath and register index widths
`define RV_XLEN 32
`define RV_REG_BITS 5

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Opcode field values, bits [6:0]
`define RV_OP_RTYPE 7'b0110011
`define RV_OP_IALU 7'b0010011
`define RV_OP_LUI 7'b0110111
`define RV_OP_LOAD 7'b0000011
`define RV_OP_STORE 7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL 7'b1101111

`endif

//--- common/rv_pipe_pkg.sv
`default_nettype none

`include "rv_pipe_config.svh"

package rv_pipe_pkg;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_rf,
    fwd_mem,
    fwd_wb
  } fwd_sel_e;

  typedef enum logic [1:0] {
    exc_none,
    exc_illegal,
    exc_misalign
  } exc_code_e;

  // One request on the shared memory port
  typedef struct packed {
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
    logic                re;
    logic                we;
  } bus_req_t;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic                    valid;
    logic [`RV_XLEN-1:0]     pc;
    logic [`RV_XLEN-1:0]     imm;
    logic [`RV_REG_BITS-1:0] rs1;
    logic [`RV_REG_BITS-1:0] rs2;
    logic [`RV_XLEN-1:0]     rs1_val;
    logic [`RV_XLEN-1:0]     rs2_val;
    logic [`RV_REG_BITS-1:0] rd;
    alu_op_e                 alu_op;
    logic                    b_imm;
    logic                    rd_rs1;
    logic                    rd_rs2;
    logic                    reg_write;
    logic                    load;
    logic                    store;
    logic                    beq;
    logic                    bne;
    logic                    jump;
    exc_code_e               exc;
  } id_ex_t;

  typedef struct packed {
    logic                    valid;
    logic [`RV_XLEN-1:0]     pc;
    logic [`RV_XLEN-1:0]     alu_result;
    logic [`RV_XLEN-1:0]     store_data;
    logic [`RV_REG_BITS-1:0] rd;
    logic                    reg_write;
    logic                    load;
    logic                    store;
    exc_code_e               exc;
  } ex_mem_t;

  typedef struct packed {
    logic                    valid;
    logic [`RV_XLEN-1:0]     pc;
    logic [`RV_REG_BITS-1:0] rd;
    logic                    reg_write;
    logic [`RV_XLEN-1:0]     data;
    exc_code_e               exc;
  } mem_wb_t;

  // Completed instruction as seen at the top
  typedef struct packed {
    logic                    valid;
    logic [`RV_XLEN-1:0]     pc;
    logic                    reg_write;
    logic [`RV_REG_BITS-1:0] rd;
    logic [`RV_XLEN-1:0]     data;
    exc_code_e               exc;
  } retire_t;

endpackage

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_config.svh"

module reg_file
  import rv_pipe_pkg::*;
(
  input  logic                    clk,
  input  logic [`RV_REG_BITS-1:0] rs1_addr,
  input  logic [`RV_REG_BITS-1:0] rs2_addr,
  input  mem_wb_t                 wb,
  output logic [`RV_XLEN-1:0]     rs1_data,
  output logic [`RV_XLEN-1:0]     rs2_data
);

  logic [`RV_XLEN-1:0] regs [2**`RV_REG_BITS];
  logic                wr_en;

  assign wr_en = wb.valid && wb.reg_write && (wb.exc == exc_none) && (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // x0 is zero, a same-cycle write is passed straight through
  assign rs1_data = (rs1_addr == '0) ? '0 :
                    (wr_en && (wb.rd == rs1_addr)) ? wb.data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 :
                    (wr_en && (wb.rd == rs2_addr)) ? wb.data : regs[rs2_addr];

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_config.svh"

module mem_arbiter
  import rv_pipe_pkg::*;
(
  input  bus_req_t            data_req,
  input  logic [`RV_XLEN-1:0] fetch_addr,
  output logic                fetch_grant,
  output bus_req_t            bus_req
);

  logic data_active;

  // Data side takes the port whenever it strobes
  assign data_active = data_req.re || data_req.we;
  assign fetch_grant = !data_active;

  always_comb begin
    if (data_active) begin
      bus_req = data_req;
    end else begin
      bus_req.addr  = fetch_addr;
      bus_req.wdata = '0;
      bus_req.re    = 1'b1;
      bus_req.we    = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_config.svh"

module hazard_unit
  import rv_pipe_pkg::*;
(
  input  id_ex_t                  id_ex,
  input  logic [`RV_REG_BITS-1:0] rs1_addr,
  input  logic [`RV_REG_BITS-1:0] rs2_addr,
  input  ex_mem_t                 ex_mem,
  input  mem_wb_t                 mem_wb,
  input  logic                    redirect_valid,
  output fwd_sel_e                a_sel,
  output fwd_sel_e                b_sel,
  output logic                    load_stall,
  output logic                    flush,
  output logic [`RV_XLEN-1:0]     wb_fwd_data
);

  logic mem_writes;
  logic wb_writes;

  assign mem_writes = ex_mem.valid && ex_mem.reg_write && (ex_mem.rd != '0);
  assign wb_writes  = mem_wb.valid && mem_wb.reg_write && (mem_wb.exc == exc_none) &&
                      (mem_wb.rd != '0);

  // Nearest producer wins
  function automatic fwd_sel_e src(input logic used, input logic [`RV_REG_BITS-1:0] rs,
                                   input logic mem_hit, input logic [`RV_REG_BITS-1:0] mem_rd,
                                   input logic wb_hit, input logic [`RV_REG_BITS-1:0] wb_rd);
    if (used && mem_hit && (mem_rd == rs)) begin
      return fwd_mem;
    end else if (used && wb_hit && (wb_rd == rs)) begin
      return fwd_wb;
    end
    return fwd_rf;
  endfunction

  assign a_sel = src(id_ex.rd_rs1, id_ex.rs1, mem_writes, ex_mem.rd, wb_writes, mem_wb.rd);
  assign b_sel = src(id_ex.rd_rs2, id_ex.rs2, mem_writes, ex_mem.rd, wb_writes, mem_wb.rd);

  // Load in EX whose result decode wants next cycle
  assign load_stall = id_ex.valid && id_ex.load && (id_ex.rd != '0) &&
                      ((id_ex.rd == rs1_addr) || (id_ex.rd == rs2_addr));

  assign flush       = redirect_valid;
  assign wb_fwd_data = mem_wb.data;

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_config.svh"

module mem_stage
  import rv_pipe_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  ex_mem_t             ex_mem,
  input  logic [`RV_XLEN-1:0] data_rdata,
  output bus_req_t            data_req,
  output logic [`RV_XLEN-1:0] mem_fwd_data,
  output mem_wb_t             mem_wb
);

  logic    access;
  logic    misaligned;
  logic    issue;
  mem_wb_t wb_next;

  // Word accesses only, low address bits must be zero
  assign access     = ex_mem.valid && (ex_mem.load || ex_mem.store);
  assign misaligned = access && (ex_mem.alu_result[1:0] != 2'b00);
  assign issue      = !misaligned && (ex_mem.exc == exc_none);

  assign data_req.addr  = ex_mem.alu_result;
  assign data_req.wdata = ex_mem.store_data;
  assign data_req.re    = ex_mem.valid && ex_mem.load && issue;
  assign data_req.we    = ex_mem.valid && ex_mem.store && issue;

  assign mem_fwd_data = ex_mem.alu_result;

  always_comb begin
    wb_next.valid     = ex_mem.valid;
    wb_next.pc        = ex_mem.pc;
    wb_next.rd        = ex_mem.rd;
    wb_next.reg_write = ex_mem.reg_write && !misaligned;
    wb_next.data      = ex_mem.load ? data_rdata : ex_mem.alu_result;
    wb_next.exc       = misaligned ? exc_misalign : ex_mem.exc;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb <= '0;
    end else begin
      mem_wb <= wb_next;
    end
  end

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_config.svh"

module fetch_unit
  import rv_pipe_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                fetch_grant,
  input  logic [`RV_XLEN-1:0] fetch_rdata,
  input  logic                load_stall,
  input  logic                flush,
  input  logic                redirect_valid,
  input  logic [`RV_XLEN-1:0] redirect_pc,
  output logic [`RV_XLEN-1:0] fetch_addr,
  output if_id_t              if_id
);

  logic [`RV_XLEN-1:0] pc;

  assign fetch_addr = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= `RV_RESET_PC;
      if_id.valid <= 1'b0;
    end else begin
      // Redirect wins, otherwise move on only when the port was ours
      if (redirect_valid) begin
        pc <= redirect_pc;
      end else if (fetch_grant && !load_stall) begin
        pc <= pc + `RV_XLEN'd4;
      end

      // Held on load-use, bubble when flushed or not granted
      if (flush) begin
        if_id.valid <= 1'b0;
      end else if (!load_stall) begin
        if_id.valid <= fetch_grant;
        if_id.pc    <= pc;
        if_id.instr <= fetch_rdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- decode/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_config.svh"

module decode_unit
  import rv_pipe_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  if_id_t                  if_id,
  input  logic [`RV_XLEN-1:0]     rs1_data,
  input  logic [`RV_XLEN-1:0]     rs2_data,
  input  logic                    load_stall,
  input  logic                    flush,
  output logic [`RV_REG_BITS-1:0] rs1_addr,
  output logic [`RV_REG_BITS-1:0] rs2_addr,
  output id_ex_t                  id_ex
);

  logic [`RV_XLEN-1:0] instr;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic                legal;
  id_ex_t              dec;

  assign instr  = if_id.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Immediate formats
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec        = '0;
    legal      = 1'b1;
    dec.valid  = if_id.valid;
    dec.pc     = if_id.pc;
    dec.rd     = instr[11:7];
    dec.alu_op = alu_add;
    case (opcode)
      `RV_OP_RTYPE: begin
        dec.rd_rs1    = 1'b1;
        dec.rd_rs2    = 1'b1;
        dec.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec.alu_op = alu_add;
          {7'b0100000, 3'b000}: dec.alu_op = alu_sub;
          {7'b0000000, 3'b111}: dec.alu_op = alu_and;
          {7'b0000000, 3'b110}: dec.alu_op = alu_or;
          {7'b0000000, 3'b100}: dec.alu_op = alu_xor;
          {7'b0000000, 3'b010}: dec.alu_op = alu_slt;
          default:              legal      = 1'b0;
        endcase
      end
      `RV_OP_IALU: begin
        // ADDI only
        dec.rd_rs1    = 1'b1;
        dec.reg_write = 1'b1;
        dec.b_imm     = 1'b1;
        dec.imm       = imm_i;
        legal         = (funct3 == 3'b000);
      end
      `RV_OP_LUI: begin
        dec.reg_write = 1'b1;
        dec.b_imm     = 1'b1;
        dec.imm       = imm_u;
        dec.alu_op    = alu_pass_b;
      end
      `RV_OP_LOAD: begin
        dec.rd_rs1    = 1'b1;
        dec.reg_write = 1'b1;
        dec.load      = 1'b1;
        dec.b_imm     = 1'b1;
        dec.imm       = imm_i;
        legal         = (funct3 == 3'b010);
      end
      `RV_OP_STORE: begin
        dec.rd_rs1 = 1'b1;
        dec.rd_rs2 = 1'b1;
        dec.store  = 1'b1;
        dec.b_imm  = 1'b1;
        dec.imm    = imm_s;
        dec.rd     = '0;
        legal      = (funct3 == 3'b010);
      end
      `RV_OP_BRANCH: begin
        dec.rd_rs1 = 1'b1;
        dec.rd_rs2 = 1'b1;
        dec.imm    = imm_b;
        dec.rd     = '0;
        dec.beq    = (funct3 == 3'b000);
        dec.bne    = (funct3 == 3'b001);
        legal      = (funct3 == 3'b000) || (funct3 == 3'b001);
      end
      `RV_OP_JAL: begin
        dec.reg_write = 1'b1;
        dec.jump      = 1'b1;
        dec.imm       = imm_j;
      end
      default: legal = 1'b0;
    endcase

    // Illegal encodings travel on as inert instructions
    if (!legal) begin
      dec.rd_rs1    = 1'b0;
      dec.rd_rs2    = 1'b0;
      dec.reg_write = 1'b0;
      dec.load      = 1'b0;
      dec.store     = 1'b0;
      dec.beq       = 1'b0;
      dec.bne       = 1'b0;
      dec.jump      = 1'b0;
      dec.exc       = exc_illegal;
    end
    if (!if_id.valid) begin
      dec = '0;
    end

    // Unused source reads as x0 so hazards see only real reads
    dec.rs1     = dec.rd_rs1 ? instr[19:15] : '0;
    dec.rs2     = dec.rd_rs2 ? instr[24:20] : '0;
    dec.rs1_val = rs1_data;
    dec.rs2_val = rs2_data;
  end

  assign rs1_addr = dec.rs1;
  assign rs2_addr = dec.rs2;

  always_ff @(posedge clk) begin
    if (rst || load_stall || flush) begin
      id_ex <= '0;
    end else begin
      id_ex <= dec;
    end
  end

endmodule

`default_nettype wire

//--- execute/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_config.svh"

module execute_unit
  import rv_pipe_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  id_ex_t              id_ex,
  input  fwd_sel_e            a_sel,
  input  fwd_sel_e            b_sel,
  input  logic [`RV_XLEN-1:0] mem_fwd_data,
  input  logic [`RV_XLEN-1:0] wb_fwd_data,
  output ex_mem_t             ex_mem,
  output logic                redirect_valid,
  output logic [`RV_XLEN-1:0] redirect_pc
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b_reg;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_out;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic                equal;
  logic                taken;
  ex_mem_t             ex_next;

  function automatic logic [`RV_XLEN-1:0] pick(input fwd_sel_e sel,
                                              input logic [`RV_XLEN-1:0] rf_val,
                                              input logic [`RV_XLEN-1:0] mem_val,
                                              input logic [`RV_XLEN-1:0] wb_val);
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return rf_val;
    endcase
  endfunction

  // Forwarded operands feed the ALU, compare and store data alike
  assign op_a     = pick(a_sel, id_ex.rs1_val, mem_fwd_data, wb_fwd_data);
  assign op_b_reg = pick(b_sel, id_ex.rs2_val, mem_fwd_data, wb_fwd_data);
  assign op_b     = id_ex.b_imm ? id_ex.imm : op_b_reg;
  assign pc_plus4 = id_ex.pc + `RV_XLEN'd4;

  // ====================
  // ALU
  // ====================
  always_comb begin
    case (id_ex.alu_op)
      alu_sub:    alu_out = op_a - op_b;
      alu_and:    alu_out = op_a & op_b;
      alu_or:     alu_out = op_a | op_b;
      alu_xor:    alu_out = op_a ^ op_b;
      alu_slt:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_pass_b: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  // ====================
  // Branch and jump
  // ====================
  assign equal = (op_a == op_b_reg);
  assign taken = id_ex.jump || (id_ex.beq && equal) || (id_ex.bne && !equal);

  assign redirect_valid = id_ex.valid && taken;
  assign redirect_pc    = id_ex.pc + id_ex.imm;

  always_comb begin
    ex_next.valid      = id_ex.valid;
    ex_next.pc         = id_ex.pc;
    ex_next.alu_result = id_ex.jump ? pc_plus4 : alu_out;
    ex_next.store_data = op_b_reg;
    ex_next.rd         = id_ex.rd;
    ex_next.reg_write  = id_ex.reg_write;
    ex_next.load       = id_ex.load;
    ex_next.store      = id_ex.store;
    ex_next.exc        = id_ex.exc;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem <= '0;
    end else begin
      ex_mem <= ex_next;
    end
  end

endmodule

`default_nettype wire

//--- design/rv_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_config.svh"

module rv_pipe_top
  import rv_pipe_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  output bus_req_t            bus_req,
  input  logic [`RV_XLEN-1:0] bus_rdata,
  output retire_t             retire
);

  if_id_t                  if_id;
  id_ex_t                  id_ex;
  ex_mem_t                 ex_mem;
  mem_wb_t                 mem_wb;
  bus_req_t                data_req;
  logic [`RV_XLEN-1:0]     fetch_addr;
  logic                    fetch_grant;
  logic [`RV_REG_BITS-1:0] rs1_addr;
  logic [`RV_REG_BITS-1:0] rs2_addr;
  logic [`RV_XLEN-1:0]     rs1_data;
  logic [`RV_XLEN-1:0]     rs2_data;
  fwd_sel_e                a_sel;
  fwd_sel_e                b_sel;
  logic [`RV_XLEN-1:0]     mem_fwd_data;
  logic [`RV_XLEN-1:0]     wb_fwd_data;
  logic                    load_stall;
  logic                    flush;
  logic                    redirect_valid;
  logic [`RV_XLEN-1:0]     redirect_pc;

  // ====================
  // Pipeline stages
  // ====================
  fetch_unit fetch_unit_i (
    .clk            (clk),
    .rst            (rst),
    .fetch_grant    (fetch_grant),
    .fetch_rdata    (bus_rdata),
    .load_stall     (load_stall),
    .flush          (flush),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .fetch_addr     (fetch_addr),
    .if_id          (if_id)
  );

  decode_unit decode_unit_i (
    .clk        (clk),
    .rst        (rst),
    .if_id      (if_id),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .load_stall (load_stall),
    .flush      (flush),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .id_ex      (id_ex)
  );

  reg_file reg_file_i (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wb       (mem_wb),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_unit execute_unit_i (
    .clk            (clk),
    .rst            (rst),
    .id_ex          (id_ex),
    .a_sel          (a_sel),
    .b_sel          (b_sel),
    .mem_fwd_data   (mem_fwd_data),
    .wb_fwd_data    (wb_fwd_data),
    .ex_mem         (ex_mem),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  mem_stage mem_stage_i (
    .clk          (clk),
    .rst          (rst),
    .ex_mem       (ex_mem),
    .data_rdata   (bus_rdata),
    .data_req     (data_req),
    .mem_fwd_data (mem_fwd_data),
    .mem_wb       (mem_wb)
  );

  // ====================
  // Control and memory port
  // ====================
  hazard_unit hazard_unit_i (
    .id_ex          (id_ex),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .ex_mem         (ex_mem),
    .mem_wb         (mem_wb),
    .redirect_valid (redirect_valid),
    .a_sel          (a_sel),
    .b_sel          (b_sel),
    .load_stall     (load_stall),
    .flush          (flush),
    .wb_fwd_data    (wb_fwd_data)
  );

  mem_arbiter mem_arbiter_i (
    .data_req    (data_req),
    .fetch_addr  (fetch_addr),
    .fetch_grant (fetch_grant),
    .bus_req     (bus_req)
  );

  // Writeback slot is the retire view
  assign retire.valid     = mem_wb.valid;
  assign retire.pc        = mem_wb.pc;
  assign retire.reg_write = mem_wb.reg_write;
  assign retire.rd        = mem_wb.rd;
  assign retire.data      = mem_wb.data;
  assign retire.exc       = mem_wb.exc;

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int RST_CYCLES = 4
) (
  input  logic restart,
  output logic clk,
  output logic rst
);

  int left;

  initial begin
    clk  = 1'b0;
    rst  = 1'b1;
    left = RST_CYCLES;
  end

  // 4 ns period
  always #2 clk = ~clk;

  // Reset reloads on restart and changes 1 ns after the edge
  always @(posedge clk) begin
    if (restart) begin
      left = RST_CYCLES;
    end else if (left > 0) begin
      left = left - 1;
    end
    #1;
    rst = (left > 0);
  end

endmodule

`default_nettype wire

//--- dv/rv_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_config.svh"

module rv_pipe_tb
  import rv_pipe_pkg::*;
();

  localparam int N_TESTS    = 6;
  localparam int MAX_WORDS  = 12;
  localparam int MEM_WORDS  = 256;
  localparam int STORE_WORD = 'h100 >> 2;
  localparam int CLK_NS     = 4;

  logic                clk;
  logic                rst;
  logic                rst_q;
  logic                restart;
  bus_req_t            bus_req;
  logic [`RV_XLEN-1:0] bus_rdata;
  retire_t             retire;
  logic [31:0]         mem [MEM_WORDS];

  // Test table
  string                   t_name [N_TESTS];
  logic [31:0]             t_prog [N_TESTS][MAX_WORDS];
  int                      t_len [N_TESTS];
  logic [31:0]             t_ret [N_TESTS][MAX_WORDS];
  int                      t_nret [N_TESTS];
  logic [31:0]             t_store [N_TESTS];
  exc_code_e               t_exc [N_TESTS];
  logic [31:0]             t_exc_pc [N_TESTS];
  bit                      t_chk_en [N_TESTS];
  logic [31:0]             t_chk_pc [N_TESTS];
  logic [31:0]             t_chk_data [N_TESTS];
  logic [`RV_REG_BITS-1:0] t_chk_rd [N_TESTS];

  retire_t     ret_q [$];
  string       cur_name;
  int          test_errs;
  int          n_pass;
  int          n_fail;
  bit          collecting;
  bit          done;
  logic [31:0] final_pc;

  tb_clock tb_clock_i (
    .restart (restart),
    .clk     (clk),
    .rst     (rst)
  );

  rv_pipe_top rv_pipe_top_i (
    .clk       (clk),
    .rst       (rst),
    .bus_req   (bus_req),
    .bus_rdata (bus_rdata),
    .retire    (retire)
  );

  // ====================
  // Memory model
  // ====================
  assign bus_rdata = mem[bus_req.addr[9:2]];

  always @(posedge clk) begin
    if (bus_req.we) begin
      mem[bus_req.addr[9:2]] <= bus_req.wdata;
    end
  end

  // ====================
  // Instruction encoders
  // ====================
  function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], `RV_OP_IALU};
  endfunction

  function automatic logic [31:0] enc_rtype(input int f7, input int f3, input int rd,
                                            input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OP_RTYPE};
  endfunction

  function automatic logic [31:0] enc_lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], `RV_OP_LOAD};
  endfunction

  function automatic logic [31:0] enc_sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic logic [31:0] enc_branch(input int f3, input int rs1, input int rs2,
                                             input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
            `RV_OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OP_JAL};
  endfunction

  // Append a word, and its pc to the retire list if it should retire
  task automatic put_instr(input int t, input logic [31:0] w, input bit retires);
    t_prog[t][t_len[t]] = w;
    if (retires) begin
      t_ret[t][t_nret[t]] = t_len[t] * 4;
      t_nret[t]++;
    end
    t_len[t]++;
  endtask

  task automatic build_table();
    for (int t = 0; t < N_TESTS; t++) begin
      t_len[t]    = 0;
      t_nret[t]   = 0;
      t_exc[t]    = exc_none;
      t_exc_pc[t] = '0;
      t_chk_en[t] = 1'b0;
      t_chk_rd[t] = '0;
    end

    t_name[0] = "reset";
    put_instr(0, enc_addi(1, 0, 5), 1);
    put_instr(0, enc_sw(1, 0, 'h100), 1);
    t_store[0] = 32'd5;

    // 7, 10, 17, 10, 27, 1, 28
    t_name[1] = "forwarding";
    put_instr(1, enc_addi(1, 0, 7), 1);
    put_instr(1, enc_addi(2, 1, 3), 1);
    put_instr(1, enc_rtype('h00, 0, 3, 1, 2), 1);
    put_instr(1, enc_rtype('h20, 0, 4, 3, 1), 1);
    put_instr(1, enc_rtype('h00, 4, 5, 4, 3), 1);
    put_instr(1, enc_rtype('h00, 2, 6, 4, 5), 1);
    put_instr(1, enc_rtype('h00, 0, 7, 5, 6), 1);
    put_instr(1, enc_sw(7, 0, 'h100), 1);
    t_store[1] = 32'd28;

    // 85 stored, reloaded, plus -3
    t_name[2] = "load_use";
    put_instr(2, enc_addi(1, 0, 85), 1);
    put_instr(2, enc_addi(4, 0, -3), 1);
    put_instr(2, enc_sw(1, 0, 'h100), 1);
    put_instr(2, enc_lw(2, 0, 'h100), 1);
    put_instr(2, enc_rtype('h00, 0, 3, 2, 4), 1);
    put_instr(2, enc_sw(3, 0, 'h100), 1);
    t_store[2] = 32'd82;

    // BEQ taken to 20, BNE falls through, JAL to 36 links 28
    t_name[3] = "control";
    put_instr(3, enc_addi(1, 0, 4), 1);
    put_instr(3, enc_addi(2, 0, 4), 1);
    put_instr(3, enc_branch(0, 1, 2, 12), 1);
    put_instr(3, enc_addi(3, 0, 99), 0);
    put_instr(3, enc_addi(3, 0, 98), 0);
    put_instr(3, enc_branch(1, 1, 2, 8), 1);
    put_instr(3, enc_jal(5, 12), 1);
    put_instr(3, enc_addi(3, 0, 77), 0);
    put_instr(3, enc_addi(3, 0, 66), 0);
    put_instr(3, enc_rtype('h00, 0, 6, 5, 1), 1);
    put_instr(3, enc_sw(6, 0, 'h100), 1);
    t_store[3]    = 32'd32;
    t_chk_en[3]   = 1'b1;
    t_chk_pc[3]   = 32'd24;
    t_chk_data[3] = 32'd28;
    t_chk_rd[3]   = 5'd5;

    t_name[4] = "illegal";
    put_instr(4, enc_addi(1, 0, 9), 1);
    put_instr(4, 32'hffff_ffff, 1);
    put_instr(4, enc_addi(1, 1, 1), 1);
    put_instr(4, enc_sw(1, 0, 'h100), 1);
    t_store[4]  = 32'd10;
    t_exc[4]    = exc_illegal;
    t_exc_pc[4] = 32'd4;

    // Misaligned LW must leave x1 at 6
    t_name[5] = "misalign";
    put_instr(5, enc_addi(1, 0, 6), 1);
    put_instr(5, enc_lw(1, 0, 2), 1);
    put_instr(5, enc_addi(1, 1, 1), 1);
    put_instr(5, enc_sw(1, 0, 'h100), 1);
    t_store[5]  = 32'd7;
    t_exc[5]    = exc_misalign;
    t_exc_pc[5] = 32'd4;
  endtask

  // ====================
  // Error reporting
  // ====================
  task automatic value_err(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %s %s: expected %h, actual %h", cur_name, what, exp, act);
    test_errs++;
  endtask

  task automatic plain_err(input string msg);
    $display("Test %s: %s", cur_name, msg);
    test_errs++;
  endtask

  // ====================
  // Monitors
  // ====================
  always @(posedge clk) begin
    rst_q <= rst;
  end

  always @(negedge clk) begin
    if (rst && rst_q) begin
      assert (!retire.valid) else plain_err("retire valid while in reset");
      assert (!bus_req.we) else plain_err("bus write strobe high while in reset");
    end
    if (!rst) begin
      if (bus_req.re || bus_req.we) begin
        assert (bus_req.addr[1:0] == 2'b00)
        else plain_err($sformatf("bus request to unaligned address %h", bus_req.addr));
      end
      if (collecting && !done && retire.valid) begin
        ret_q.push_back(retire);
        if (retire.pc == final_pc) begin
          done = 1'b1;
        end
      end
    end
  end

  initial begin
    #(N_TESTS * 40 * CLK_NS);
    $display("Watchdog expired before all tests finished");
    $display("Something failed");
    $finish;
  end

  // ====================
  // Test sequence
  // ====================
  task automatic run_test(input int t);
    logic [31:0] rnd;
    bit          seen_exc;
    bit          seen_chk;

    cur_name   = t_name[t];
    test_errs  = 0;
    collecting = 1'b0;
    @(posedge clk);
    #1;
    restart = 1'b1;
    @(posedge clk);
    #1;
    restart = 1'b0;
    @(posedge clk);
    #1;

    // Random fill keeps opcode 7f so stray fetches never look legal
    for (int i = 0; i < MEM_WORDS; i++) begin
      rnd    = $urandom();
      mem[i] = {rnd[31:7], 7'h7f};
    end
    for (int i = 0; i < t_len[t]; i++) begin
      mem[i] = t_prog[t][i];
    end
    mem[STORE_WORD] = 32'hdead_beef;
    ret_q.delete();
    done       = 1'b0;
    final_pc   = t_ret[t][t_nret[t]-1];
    collecting = 1'b1;

    while (rst) begin
      @(negedge clk);
    end
    assert (bus_req.addr == `RV_RESET_PC) else value_err("first fetch address",
                                                         `RV_RESET_PC, bus_req.addr);
    assert (bus_req.re) else plain_err("no read strobe on the first fetch");

    while (!done) begin
      @(posedge clk);
    end
    #1;
    collecting = 1'b0;

    assert (mem[STORE_WORD] == t_store[t])
    else value_err("store at 0x100", t_store[t], mem[STORE_WORD]);
    assert (ret_q.size() == t_nret[t])
    else value_err("retire count", t_nret[t], ret_q.size());
    for (int i = 0; i < ret_q.size() && i < t_nret[t]; i++) begin
      assert (ret_q[i].pc == t_ret[t][i])
      else value_err($sformatf("retire %0d pc", i), t_ret[t][i], ret_q[i].pc);
    end

    seen_exc = 1'b0;
    seen_chk = 1'b0;
    foreach (ret_q[i]) begin
      if (t_exc[t] != exc_none && ret_q[i].pc == t_exc_pc[t]) begin
        seen_exc = 1'b1;
        assert (ret_q[i].exc == t_exc[t])
        else value_err("exception code", 32'(t_exc[t]), 32'(ret_q[i].exc));
        assert (!ret_q[i].reg_write)
        else value_err("register write flag", 32'd0, 32'd1);
      end else begin
        assert (ret_q[i].exc == exc_none)
        else value_err($sformatf("exception code at pc %h", ret_q[i].pc), 32'(exc_none),
                       32'(ret_q[i].exc));
      end
      if (t_chk_en[t] && ret_q[i].pc == t_chk_pc[t]) begin
        seen_chk = 1'b1;
        assert (ret_q[i].data == t_chk_data[t])
        else value_err("link data", t_chk_data[t], ret_q[i].data);
        assert (ret_q[i].rd == t_chk_rd[t])
        else value_err("link rd", 32'(t_chk_rd[t]), 32'(ret_q[i].rd));
      end
    end
    assert (seen_exc || t_exc[t] == exc_none)
    else plain_err("the faulting instruction never retired");
    assert (seen_chk || !t_chk_en[t]) else plain_err("the JAL never retired");

    if (test_errs == 0) begin
      $display("test %-10s passed", cur_name);
      n_pass++;
    end else begin
      $display("test %-10s failed with %0d errors", cur_name, test_errs);
      n_fail++;
    end
  endtask

  initial begin
    restart    = 1'b0;
    collecting = 1'b0;
    done       = 1'b0;
    final_pc   = '0;
    n_pass     = 0;
    n_fail     = 0;
    test_errs  = 0;
    cur_name   = "startup";
    void'($urandom(32'h1bb6aeef));
    build_table();

    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end

    $display("%0d tests run, %0d passed, %0d failed", N_TESTS, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_pipe.f
+incdir+common
common/rv_pipe_pkg.sv
design/reg_file.sv
design/mem_arbiter.sv
design/hazard_unit.sv
design/mem_stage.sv
fetch/fetch_unit.sv
decode/decode_unit.sv
execute/execute_unit.sv
design/rv_pipe_top.sv
dv/tb_clock.sv
dv/rv_pipe_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_pipe_tb -f rv_pipe.f -o rv_pipe_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/rv_pipe_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
